// File: all.f
+incdir+hw
hw/uart_pkg.sv
hw/uart_reg_decode.sv
hw/uart_baud_gen.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_top.sv
verif/uart_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module uart_tb -f all.f -o uart_tb_sim
./obj_dir/uart_tb_sim | tee sim.log
if grep -q "Checks failed" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
grep -q "All checks passed" sim.log
echo "Simulation finished cleanly"

// File: verif/uart_tb.sv
`default_nettype none
`include "uart_cfg.svh"

module uart_tb
	import uart_pkg::*;
();

	localparam int TB_DIV = 1;
	localparam int BIT_CLOCKS = `UART_OVERSAMPLE * (TB_DIV + 1);
	localparam int FRAME_CYCLES = BIT_CLOCKS * (`UART_DATA_BITS + 3);
	localparam int TIMEOUT_CYCLES = 40 * FRAME_CYCLES;
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic clk;
	logic reset;
	axil_req_t axi_req;
	axil_resp_t axi_resp;
	logic tx_line;
	logic rx_line;
	logic serial_line;
	logic tb_rx_override;
	logic request_seen;

	// The receiver hears either the transmitter or the serial line model.
	assign rx_line = tb_rx_override ? serial_line : tx_line;

	uart_top uart_top_i
	(
		.clk(clk),
		.reset(reset),
		.axi_req(axi_req),
		.axi_resp(axi_resp),
		.tx(tx_line),
		.rx(rx_line)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic expect_equal(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
			abort_run($sformatf("FAILED %s expected 0x%h got 0x%h", name, expected, actual));
	endtask

	// Even parity is the XOR of the data bits, odd parity its inverse.
	function automatic logic expected_parity(input logic [`UART_DATA_BITS-1:0] value,
		input logic odd);
		logic ones;
		ones = 1'b0;
		for (int i = 0; i < `UART_DATA_BITS; i++)
			ones = ones ^ value[i];
		return odd ? ~ones : ones;
	endfunction

	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
		input logic [1:0] expected_resp);
		int unsigned delay;
		delay = $urandom_range(0, 7);
		request_seen = 1'b1;
		axi_req.awvalid = 1'b1;
		axi_req.awaddr = addr;
		axi_req.wvalid = 1'b1;
		axi_req.wdata = data;
		axi_req.wstrb = 4'hF;
		@(negedge clk);
		while (!axi_resp.awready)
			@(negedge clk);
		expect_equal("wready", 32'h1, 32'(axi_resp.wready));
		@(negedge clk);
		axi_req.awvalid = 1'b0;
		axi_req.wvalid = 1'b0;
		while (!axi_resp.bvalid)
			@(negedge clk);
		repeat (delay) @(negedge clk);
		expect_equal("bresp", 32'(expected_resp), 32'(axi_resp.bresp));
		axi_req.bready = 1'b1;
		@(negedge clk);
		axi_req.bready = 1'b0;
	endtask

	task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
		int unsigned delay;
		delay = $urandom_range(0, 7);
		request_seen = 1'b1;
		axi_req.arvalid = 1'b1;
		axi_req.araddr = addr;
		@(negedge clk);
		while (!axi_resp.arready)
			@(negedge clk);
		@(negedge clk);
		axi_req.arvalid = 1'b0;
		while (!axi_resp.rvalid)
			@(negedge clk);
		repeat (delay) @(negedge clk);
		expect_equal("rresp", 32'(RESP_OKAY), 32'(axi_resp.rresp));
		data = axi_resp.rdata;
		axi_req.rready = 1'b1;
		@(negedge clk);
		axi_req.rready = 1'b0;
	endtask

	// Returns once a byte is held and the transmitter is idle.
	task automatic wait_rx_ready(output logic [31:0] status);
		axi_read(REG_STATUS, status);
		while (!status[1] || status[0])
			axi_read(REG_STATUS, status);
	endtask

	task automatic loopback_byte(input logic [`UART_DATA_BITS-1:0] value);
		logic [31:0] word;
		axi_write(REG_DATA, 32'(value), RESP_OKAY);
		wait_rx_ready(word);
		expect_equal("STATUS", 32'h2, word);
		axi_read(REG_DATA, word);
		expect_equal("DATA", 32'(value), word);
	endtask

	task automatic send_frame(input logic [`UART_DATA_BITS-1:0] value, input logic parity_bit,
		input logic stop_bit);
		serial_line = 1'b0;
		repeat (BIT_CLOCKS) @(negedge clk);
		for (int i = 0; i < `UART_DATA_BITS; i++)
		begin
			serial_line = value[i];
			repeat (BIT_CLOCKS) @(negedge clk);
		end
		serial_line = parity_bit;
		repeat (BIT_CLOCKS) @(negedge clk);
		serial_line = stop_bit;
		repeat (BIT_CLOCKS) @(negedge clk);
		serial_line = 1'b1;
		repeat (BIT_CLOCKS) @(negedge clk);
	endtask

	// Samples tx at each bit center of one even-parity frame.
	task automatic watch_line_format(input logic [`UART_DATA_BITS-1:0] value);
		logic [`UART_DATA_BITS+2:0] bits;
		bits = {1'b1, expected_parity(value, 1'b0), value, 1'b0};
		while (tx_line)
			@(negedge clk);
		repeat (BIT_CLOCKS / 2) @(negedge clk);
		for (int i = 0; i < `UART_DATA_BITS + 3; i++)
		begin
			expect_equal($sformatf("tx bit %0d", i), 32'(bits[i]), 32'(tx_line));
			repeat (BIT_CLOCKS) @(negedge clk);
		end
	endtask

	bvalid_held: assert property (@(posedge clk) disable iff (reset)
		axi_resp.bvalid && !axi_req.bready |=> axi_resp.bvalid)
		else abort_run("bvalid dropped before bready was high");

	rvalid_held: assert property (@(posedge clk) disable iff (reset)
		axi_resp.rvalid && !axi_req.rready |=> axi_resp.rvalid && $stable(axi_resp.rdata))
		else abort_run("rvalid or rdata changed while waiting for rready");

	quiet_until_request: assert property (@(posedge clk) disable iff (reset)
		!request_seen |-> !(axi_resp.awready || axi_resp.wready || axi_resp.bvalid
			|| axi_resp.arready || axi_resp.rvalid))
		else abort_run("AXI response signals were active before any request");

	initial
	begin
		int cycles;
		cycles = 0;
		forever
		begin
			@(posedge clk);
			cycles++;
			if (cycles >= TIMEOUT_CYCLES)
				abort_run($sformatf("Timeout: tests did not finish in %0d cycles", cycles));
		end
	end

	initial
	begin
		logic [31:0] word;
		logic [`UART_DATA_BITS-1:0] first_byte;
		logic [`UART_DATA_BITS-1:0] second_byte;
		parity_mode_t mode;
		void'($urandom(32'hd6ae13cd));
		reset = 1'b1;
		axi_req = '0;
		serial_line = 1'b1;
		tb_rx_override = 1'b0;
		request_seen = 1'b0;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		expect_equal("tx", 32'h1, 32'(tx_line));
		axi_read(REG_STATUS, word);
		expect_equal("STATUS", 32'h0, word);
		axi_read(REG_CTRL, word);
		expect_equal("CTRL", 32'h0, word);
		axi_read(REG_DIV, word);
		expect_equal("DIV", 32'(`UART_DEFAULT_DIV), word);
		axi_write(REG_DIV, 32'(TB_DIV), RESP_OKAY);
		axi_read(REG_DIV, word);
		expect_equal("DIV", 32'(TB_DIV), word);

		// Loopback in each parity mode, with the line format watched once.
		for (int m = 0; m < 3; m++)
		begin
			mode = parity_mode_t'(m);
			axi_write(REG_CTRL, 32'(mode), RESP_OKAY);
			for (int i = 0; i < 4; i++)
			begin
				first_byte = `UART_DATA_BITS'($urandom);
				if (mode == PARITY_EVEN && i == 0)
				begin
					fork
						watch_line_format(first_byte);
						loopback_byte(first_byte);
					join
				end
				else
					loopback_byte(first_byte);
			end
		end

		axi_write(REG_CTRL, 32'(PARITY_EVEN), RESP_OKAY);
		tb_rx_override = 1'b1;
		first_byte = `UART_DATA_BITS'($urandom);
		send_frame(first_byte, ~expected_parity(first_byte, 1'b0), 1'b1);
		wait_rx_ready(word);
		expect_equal("STATUS", 32'h6, word);
		axi_read(REG_DATA, word);
		expect_equal("DATA", 32'(first_byte), word);
		second_byte = `UART_DATA_BITS'($urandom);
		send_frame(second_byte, expected_parity(second_byte, 1'b0), 1'b0);
		wait_rx_ready(word);
		expect_equal("STATUS", 32'hE, word);
		axi_read(REG_DATA, word);
		axi_write(REG_STATUS, 32'h1C, RESP_OKAY);
		axi_read(REG_STATUS, word);
		expect_equal("STATUS", 32'h0, word);

		// Two frames without a read of DATA in between.
		first_byte = `UART_DATA_BITS'($urandom);
		second_byte = first_byte ^ 8'hA5;
		send_frame(first_byte, expected_parity(first_byte, 1'b0), 1'b1);
		send_frame(second_byte, expected_parity(second_byte, 1'b0), 1'b1);
		wait_rx_ready(word);
		expect_equal("STATUS", 32'h12, word);
		axi_read(REG_DATA, word);
		expect_equal("DATA", 32'(second_byte), word);
		axi_write(REG_STATUS, 32'h10, RESP_OKAY);
		axi_read(REG_STATUS, word);
		expect_equal("STATUS", 32'h0, word);

		// The second write finds the transmitter busy and is dropped.
		tb_rx_override = 1'b0;
		first_byte = `UART_DATA_BITS'($urandom);
		second_byte = ~first_byte;
		axi_write(REG_DATA, 32'(first_byte), RESP_OKAY);
		axi_write(REG_DATA, 32'(second_byte), RESP_SLVERR);
		wait_rx_ready(word);
		axi_read(REG_DATA, word);
		expect_equal("DATA", 32'(first_byte), word);
		repeat (FRAME_CYCLES) @(negedge clk);
		axi_read(REG_STATUS, word);
		expect_equal("STATUS", 32'h0, word);

		for (int i = 0; i < 4; i++)
		begin
			mode = parity_mode_t'($urandom_range(0, 2));
			axi_write(REG_CTRL, 32'(mode), RESP_OKAY);
			axi_read(REG_CTRL, word);
			expect_equal("CTRL", 32'(mode), word);
		end

		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/uart_top.sv
`default_nettype none
`include "uart_cfg.svh"

module uart_top
	import uart_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire axil_req_t axi_req,
	output axil_resp_t axi_resp,
	output logic tx,
	input wire rx
);

	uart_ctrl_t ctrl;
	uart_rx_result_t rx_result;
	logic [`UART_DATA_BITS-1:0] tx_data;
	logic tx_start;
	logic tx_busy;
	logic rx_done;
	logic tick;

	uart_reg_decode uart_reg_decode_i
	(
		.clk(clk),
		.reset(reset),
		.axi_req(axi_req),
		.axi_resp(axi_resp),
		.ctrl(ctrl),
		.tx_start(tx_start),
		.tx_data(tx_data),
		.tx_busy(tx_busy),
		.rx_done(rx_done),
		.rx_result(rx_result)
	);

	uart_baud_gen uart_baud_gen_i
	(
		.clk(clk),
		.reset(reset),
		.divisor(ctrl.divisor),
		.tick(tick)
	);

	uart_tx uart_tx_i
	(
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.parity_mode(ctrl.parity_mode),
		.start(tx_start),
		.data(tx_data),
		.busy(tx_busy),
		.tx(tx)
	);

	uart_rx uart_rx_i
	(
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.parity_mode(ctrl.parity_mode),
		.rx(rx),
		.done(rx_done),
		.result(rx_result)
	);

endmodule

`default_nettype wire

// File: hw/uart_rx.sv
`default_nettype none
`include "uart_cfg.svh"

module uart_rx
	import uart_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire tick,
	input wire parity_mode_t parity_mode,
	input wire rx,
	output logic done,
	output uart_rx_result_t result
);

	localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
	localparam int BIT_W = $clog2(`UART_DATA_BITS);
	localparam logic [TICK_W-1:0] MID_TICK = TICK_W'(`UART_OVERSAMPLE / 2 - 1);
	localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(`UART_OVERSAMPLE - 1);
	localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(`UART_DATA_BITS - 1);

	typedef enum logic [2:0] {S_IDLE, S_START, S_DATA, S_PARITY, S_STOP} state_t;

	state_t state;
	parity_mode_t mode_q;
	logic [TICK_W-1:0] tick_cnt;
	logic [BIT_W-1:0] bit_cnt;
	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic bit_end;
	logic [`UART_DATA_BITS-1:0] shift;
	logic par_sample;

	// After the start bit is confirmed, every bit end lands on a bit center.
	assign bit_end = tick && tick_cnt == LAST_TICK;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
			state <= S_IDLE;
			mode_q <= PARITY_NONE;
			tick_cnt <= '0;
			bit_cnt <= '0;
			done <= 1'b0;
		end
		else
		begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
			done <= 1'b0;
			if (tick && state != S_IDLE)
				tick_cnt <= (tick_cnt == LAST_TICK) ? '0 : tick_cnt + 1'b1;
			case (state)
				S_IDLE:
				begin
					if (rx_prev && !rx_sync)
					begin
						state <= S_START;
						tick_cnt <= '0;
						mode_q <= parity_mode;
					end
				end
				S_START:
				begin
					if (tick && tick_cnt == MID_TICK)
					begin
						// A line that is high again was only a glitch.
						state <= rx_sync ? S_IDLE : S_DATA;
						tick_cnt <= '0;
						bit_cnt <= '0;
					end
				end
				S_DATA:
				begin
					if (bit_end)
					begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == LAST_BIT)
							state <= (mode_q != PARITY_NONE) ? S_PARITY : S_STOP;
					end
				end
				S_PARITY:
				begin
					if (bit_end)
						state <= S_STOP;
				end
				S_STOP:
				begin
					if (bit_end)
					begin
						state <= S_IDLE;
						done <= 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == S_DATA && bit_end)
			shift <= {rx_sync, shift[`UART_DATA_BITS-1:1]};
		if (state == S_PARITY && bit_end)
			par_sample <= rx_sync;
		if (state == S_STOP && bit_end)
		begin
			result.data <= shift;
			result.parity_err <= mode_q != PARITY_NONE && par_sample != calc_parity(shift, mode_q);
			result.frame_err <= !rx_sync;
		end
	end

endmodule

`default_nettype wire

// File: hw/uart_tx.sv
`default_nettype none
`include "uart_cfg.svh"

module uart_tx
	import uart_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire tick,
	input wire parity_mode_t parity_mode,
	input wire start,
	input wire [`UART_DATA_BITS-1:0] data,
	output logic busy,
	output logic tx
);

	localparam int MAX_TICKS = (`UART_STOP_TICKS > `UART_OVERSAMPLE) ?
		`UART_STOP_TICKS : `UART_OVERSAMPLE;
	localparam int TICK_W = $clog2(MAX_TICKS);
	localparam int BIT_W = $clog2(`UART_DATA_BITS);
	localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(`UART_OVERSAMPLE - 1);
	localparam logic [TICK_W-1:0] STOP_LAST = TICK_W'(`UART_STOP_TICKS - 1);
	localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(`UART_DATA_BITS - 1);

	typedef enum logic [2:0] {S_IDLE, S_START, S_DATA, S_PARITY, S_STOP} state_t;

	state_t state_q, state_d;
	logic [TICK_W-1:0] tick_q, tick_d;
	logic [BIT_W-1:0] bit_q, bit_d;
	logic [`UART_DATA_BITS-1:0] shift_q, shift_d;
	logic par_bit_q, par_bit_d;
	logic par_en_q, par_en_d;
	logic tx_q, tx_d;
	logic bit_end;

	assign bit_end = tick && tick_q == LAST_TICK;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state_q <= S_IDLE;
			tick_q <= '0;
			bit_q <= '0;
			par_en_q <= 1'b0;
			tx_q <= 1'b1;
		end
		else
		begin
			state_q <= state_d;
			tick_q <= tick_d;
			bit_q <= bit_d;
			par_en_q <= par_en_d;
			tx_q <= tx_d;
		end
	end

	always_ff @(posedge clk)
	begin
		shift_q <= shift_d;
		par_bit_q <= par_bit_d;
	end

	always_comb
	begin
		state_d = state_q;
		tick_d = (tick && state_q != S_IDLE) ? tick_q + 1'b1 : tick_q;
		bit_d = bit_q;
		shift_d = shift_q;
		par_bit_d = par_bit_q;
		par_en_d = par_en_q;
		case (state_q)
			S_IDLE:
			begin
				if (start)
				begin
					state_d = S_START;
					tick_d = '0;
					shift_d = data;
					// Parity and mode are frozen for the whole frame.
					par_bit_d = calc_parity(data, parity_mode);
					par_en_d = parity_mode != PARITY_NONE;
				end
			end
			S_START:
			begin
				if (bit_end)
				begin
					state_d = S_DATA;
					tick_d = '0;
					bit_d = '0;
				end
			end
			S_DATA:
			begin
				if (bit_end)
				begin
					tick_d = '0;
					shift_d = shift_q >> 1;
					bit_d = bit_q + 1'b1;
					if (bit_q == LAST_BIT)
						state_d = par_en_q ? S_PARITY : S_STOP;
				end
			end
			S_PARITY:
			begin
				if (bit_end)
				begin
					tick_d = '0;
					state_d = S_STOP;
				end
			end
			S_STOP:
			begin
				if (tick && tick_q == STOP_LAST)
					state_d = S_IDLE;
			end
			default: state_d = S_IDLE;
		endcase

		// The line level follows the state being entered.
		case (state_d)
			S_START:  tx_d = 1'b0;
			S_DATA:   tx_d = shift_d[0];
			S_PARITY: tx_d = par_bit_d;
			default:  tx_d = 1'b1;
		endcase
	end

	assign busy = state_q != S_IDLE;
	assign tx = tx_q;

	a_idle_high: assert property (@(posedge clk) disable iff (reset)
		state_q == S_IDLE |-> tx);

endmodule

`default_nettype wire

// File: hw/uart_baud_gen.sv
`default_nettype none
`include "uart_cfg.svh"

module uart_baud_gen
(
	input wire clk,
	input wire reset,
	input wire [15:0] divisor,
	output logic tick
);

	logic [15:0] count;
	logic [15:0] divisor_q;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			count <= `UART_DEFAULT_DIV;
			divisor_q <= `UART_DEFAULT_DIV;
			tick <= 1'b0;
		end
		else
		begin
			divisor_q <= divisor;
			tick <= 1'b0;
			// A new divisor restarts the period from the top.
			if (divisor != divisor_q)
				count <= divisor;
			else if (count == '0)
			begin
				count <= divisor;
				tick <= 1'b1;
			end
			else
				count <= count - 16'd1;
		end
	end

	a_tick_single: assert property (@(posedge clk) disable iff (reset)
		tick && divisor != '0 |=> !tick);

endmodule

`default_nettype wire

// File: hw/uart_reg_decode.sv
`default_nettype none
`include "uart_cfg.svh"

module uart_reg_decode
	import uart_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire axil_req_t axi_req,
	output axil_resp_t axi_resp,
	output uart_ctrl_t ctrl,
	output logic tx_start,
	output logic [`UART_DATA_BITS-1:0] tx_data,
	input wire tx_busy,
	input wire rx_done,
	input wire uart_rx_result_t rx_result
);

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic aw_ready_q;
	logic ar_ready_q;
	logic bvalid_q;
	logic [1:0] bresp_q;
	logic rvalid_q;
	logic [31:0] rdata_q;
	logic [31:0] read_word;
	logic wr_fire;
	logic ar_fire;
	logic wr_err;
	logic busy_status;
	reg_addr_t wr_addr;
	reg_addr_t rd_addr;
	uart_ctrl_t ctrl_q;
	logic [`UART_DATA_BITS-1:0] rx_data_q;
	logic rx_valid_q;
	logic parity_err_q;
	logic frame_err_q;
	logic overrun_q;
	logic tx_start_q;
	logic [`UART_DATA_BITS-1:0] tx_data_q;

	// Only bits 3:2 select a register, so every offset maps onto one of the four.
	assign wr_addr = reg_addr_t'({axi_req.awaddr[3:2], 2'b00});
	assign rd_addr = reg_addr_t'({axi_req.araddr[3:2], 2'b00});
	assign wr_fire = aw_ready_q && axi_req.awvalid && axi_req.wvalid;
	assign ar_fire = ar_ready_q && axi_req.arvalid;

	// A start already issued counts as busy until the transmitter reports it.
	assign busy_status = tx_busy || tx_start_q;
	assign wr_err = !(|axi_req.wstrb) || (wr_addr == REG_DATA && busy_status);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			aw_ready_q <= 1'b0;
			ar_ready_q <= 1'b0;
			bvalid_q <= 1'b0;
			bresp_q <= RESP_OKAY;
			rvalid_q <= 1'b0;
		end
		else
		begin
			aw_ready_q <= axi_req.awvalid && axi_req.wvalid && !aw_ready_q && !bvalid_q;
			ar_ready_q <= axi_req.arvalid && !ar_ready_q && !rvalid_q;
			if (wr_fire)
			begin
				bvalid_q <= 1'b1;
				bresp_q <= wr_err ? RESP_SLVERR : RESP_OKAY;
			end
			else if (axi_req.bready)
				bvalid_q <= 1'b0;
			if (ar_fire)
				rvalid_q <= 1'b1;
			else if (axi_req.rready)
				rvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			ctrl_q.parity_mode <= PARITY_NONE;
			ctrl_q.divisor <= `UART_DEFAULT_DIV;
			rx_valid_q <= 1'b0;
			parity_err_q <= 1'b0;
			frame_err_q <= 1'b0;
			overrun_q <= 1'b0;
			tx_start_q <= 1'b0;
		end
		else
		begin
			tx_start_q <= 1'b0;
			if (wr_fire && !wr_err)
			begin
				case (wr_addr)
					REG_DATA: tx_start_q <= axi_req.wstrb[0];
					REG_STATUS:
					begin
						if (axi_req.wstrb[0])
						begin
							parity_err_q <= parity_err_q && !axi_req.wdata[2];
							frame_err_q <= frame_err_q && !axi_req.wdata[3];
							overrun_q <= overrun_q && !axi_req.wdata[4];
						end
					end
					REG_CTRL:
					begin
						if (axi_req.wstrb[0])
							ctrl_q.parity_mode <= parity_mode_t'(axi_req.wdata[1:0]);
					end
					REG_DIV:
					begin
						if (axi_req.wstrb[0])
							ctrl_q.divisor[7:0] <= axi_req.wdata[7:0];
						if (axi_req.wstrb[1])
							ctrl_q.divisor[15:8] <= axi_req.wdata[15:8];
					end
				endcase
			end
			if (ar_fire && rd_addr == REG_DATA)
				rx_valid_q <= 1'b0;
			// A new frame wins over a clear in the same cycle.
			if (rx_done)
			begin
				rx_valid_q <= 1'b1;
				parity_err_q <= parity_err_q || rx_result.parity_err;
				frame_err_q <= frame_err_q || rx_result.frame_err;
				if (rx_valid_q)
					overrun_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_fire && !wr_err && wr_addr == REG_DATA)
			tx_data_q <= axi_req.wdata[`UART_DATA_BITS-1:0];
		if (rx_done)
			rx_data_q <= rx_result.data;
		if (ar_fire)
			rdata_q <= read_word;
	end

	always_comb
	begin
		read_word = '0;
		case (rd_addr)
			REG_DATA:   read_word[`UART_DATA_BITS-1:0] = rx_data_q;
			REG_STATUS: read_word[4:0] = {overrun_q, frame_err_q, parity_err_q, rx_valid_q,
				busy_status};
			REG_CTRL:   read_word[1:0] = ctrl_q.parity_mode;
			REG_DIV:    read_word[15:0] = ctrl_q.divisor;
		endcase
	end

	always_comb
	begin
		axi_resp.awready = aw_ready_q;
		axi_resp.wready = aw_ready_q;
		axi_resp.bvalid = bvalid_q;
		axi_resp.bresp = bresp_q;
		axi_resp.arready = ar_ready_q;
		axi_resp.rvalid = rvalid_q;
		axi_resp.rdata = rdata_q;
		axi_resp.rresp = RESP_OKAY;
	end

	assign ctrl = ctrl_q;
	assign tx_start = tx_start_q;
	assign tx_data = tx_data_q;

	a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
		axi_resp.bvalid && !axi_req.bready |=> axi_resp.bvalid);

	// The transmitter must be idle whenever a new frame is launched.
	a_start_idle: assert property (@(posedge clk) disable iff (reset)
		$rose(tx_start) |-> !tx_busy);

endmodule

`default_nettype wire

// File: hw/uart_pkg.sv
`default_nettype none
`include "uart_cfg.svh"

package uart_pkg;

	typedef enum logic [1:0]
	{
		PARITY_NONE = 2'd0,
		PARITY_EVEN = 2'd1,
		PARITY_ODD  = 2'd2
	} parity_mode_t;

	typedef struct packed
	{
		parity_mode_t parity_mode;
		logic [15:0] divisor;
	} uart_ctrl_t;

	typedef struct packed
	{
		logic [`UART_DATA_BITS-1:0] data;
		logic parity_err;
		logic frame_err;
	} uart_rx_result_t;

	typedef struct packed
	{
		logic awvalid;
		logic [3:0] awaddr;
		logic wvalid;
		logic [31:0] wdata;
		logic [3:0] wstrb;
		logic bready;
		logic arvalid;
		logic [3:0] araddr;
		logic rready;
	} axil_req_t;

	typedef struct packed
	{
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
		logic arready;
		logic rvalid;
		logic [31:0] rdata;
		logic [1:0] rresp;
	} axil_resp_t;

	typedef enum logic [3:0]
	{
		REG_DATA   = 4'h0,
		REG_STATUS = 4'h4,
		REG_CTRL   = 4'h8,
		REG_DIV    = 4'hC
	} reg_addr_t;

	// Even mode makes the count of ones in data plus parity even.
	function automatic logic calc_parity(input logic [`UART_DATA_BITS-1:0] data,
		input parity_mode_t mode);
		logic ones;
		ones = ^data;
		case (mode)
			PARITY_EVEN: return ones;
			PARITY_ODD:  return ~ones;
			default:     return 1'b0;
		endcase
	endfunction

endpackage

`default_nettype wire

// File: hw/uart_cfg.svh
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// Data bits in each frame, sent LSB first.
`define UART_DATA_BITS 8

// Baud ticks per bit period.
`define UART_OVERSAMPLE 16

// Baud ticks spent in the stop bit.
`define UART_STOP_TICKS 16

// Divisor after reset. The tick period is divisor + 1 clocks.
`define UART_DEFAULT_DIV 16'd325

`endif
